//--- rtl/insn_pkg.sv
////////////////////////////////////////////////////////////
// Instruction word layout: 32 data bits, 7 inverted check bits on top.
// Check bits are plain parities over masked data, no correction.
////////////////////////////////////////////////////////////
`default_nettype none

package insn_pkg;

  parameter int InsnW        = 32;
  parameter int InsnIntgChkW = 7;

  typedef logic [InsnW-1:0]              insn_t;
  typedef logic [InsnIntgChkW+InsnW-1:0] insn_intg_t;
  typedef logic [InsnIntgChkW-1:0]       insn_chk_t;
  typedef logic [6:0]                    insn_opcode_t;

  // Base RISC-V opcodes that change the flow of control
  parameter insn_opcode_t InsnOpcodeBranch = 7'b1100011;
  parameter insn_opcode_t InsnOpcodeJal    = 7'b1101111;
  parameter insn_opcode_t InsnOpcodeJalr   = 7'b1100111;

  // Check bit k is the parity of the data bits picked by mask k
  parameter logic [InsnIntgChkW-1:0][InsnW-1:0] InsnIntgMask = '{
    32'h9850_5586,
    32'h2DCC_624C,
    32'hC2C1_323B,
    32'h3123_4ED1,
    32'h413D_89AA,
    32'hDEBA_8050,
    32'h2606_BD25
  };

  // Applied to the stored check bits so an all-zero word is not a valid codeword
  parameter insn_chk_t InsnIntgInv = 7'b0101010;

endpackage

`default_nettype wire

//--- rtl/ifetch_pkg.sv
////////////////////////////////////////////////////////////
// Fetch stage configuration. Memory size must be a power of two.
////////////////////////////////////////////////////////////
`default_nettype none

package ifetch_pkg;

  // Default instruction memory size in bytes
  parameter int ImemSizeByteDefault = 4096;

  // Remaining iterations of the innermost hardware loop
  typedef logic [31:0] loop_iter_t;

endpackage

`default_nettype wire

//--- rtl/ifetch_intg_check.sv
////////////////////////////////////////////////////////////
// Detect-only integrity check of the held word; single error
// flag, no syndrome and no correction.
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module ifetch_intg_check (
  input  insn_pkg::insn_intg_t word_i,
  input  logic                 valid_i,
  output logic                 intg_err_o
);

  import insn_pkg::*;

  insn_t     data;
  insn_chk_t chk_stored;
  insn_chk_t chk_calc;

  assign data = word_i[InsnW-1:0];

  // Undo the inversion applied when the word was written
  assign chk_stored = word_i[InsnW+:InsnIntgChkW] ^ InsnIntgInv;

  always_comb begin
    for (int k = 0; k < InsnIntgChkW; k++) begin
      chk_calc[k] = ^(data & InsnIntgMask[k]);
    end
  end

  // Only meaningful while the response register holds a fetched word
  assign intg_err_o = valid_i & |(chk_calc ^ chk_stored);

endmodule

`default_nettype wire

//--- rtl/ifetch_resp.sv
////////////////////////////////////////////////////////////
// Fetch response register. Holds until the next fetch;
// a clear only drops the valid flag.
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module ifetch_resp #(
  parameter int ImemAddrWidth = 12
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  input  logic                     fetch_en_i,
  input  logic [ImemAddrWidth-1:0] fetch_addr_i,
  input  insn_pkg::insn_intg_t     imem_rdata_i,
  input  logic                     resp_clear_i,

  output logic                     resp_valid_o,
  output logic [ImemAddrWidth-1:0] resp_addr_o,
  output insn_pkg::insn_intg_t     resp_word_o
);

  import insn_pkg::*;

  logic                     resp_valid_q;
  logic [ImemAddrWidth-1:0] resp_addr_q;
  insn_intg_t               resp_word_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_q <= 1'b0;
      resp_word_q  <= '0;
    end else if (fetch_en_i) begin
      resp_valid_q <= 1'b1;
      resp_word_q  <= imem_rdata_i;
    end else if (resp_clear_i) begin
      resp_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_en_i) begin
      resp_addr_q <= fetch_addr_i;
    end
  end

  assign resp_valid_o = resp_valid_q;
  assign resp_addr_o  = resp_addr_q;
  assign resp_word_o  = resp_word_q;

endmodule

`default_nettype wire

//--- rtl/ifetch_prefetch.sv
////////////////////////////////////////////////////////////
// Prefetch control. Assumes the memory answers every request
// exactly one cycle later and can never stall.
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module ifetch_prefetch #(
  parameter int ImemAddrWidth = 12
) (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  input  insn_pkg::insn_intg_t       imem_rdata_i,
  input  logic                       imem_rvalid_i,
  output logic [ImemAddrWidth-1:0]   imem_addr_o,

  input  logic                       insn_fetch_req_valid_i,
  input  logic [ImemAddrWidth-1:0]   insn_fetch_req_addr_i,

  input  logic                       prefetch_en_i,
  input  logic                       prefetch_loop_active_i,
  input  ifetch_pkg::loop_iter_t     prefetch_loop_iterations_i,
  input  logic [ImemAddrWidth:0]     prefetch_loop_end_addr_i,
  input  logic [ImemAddrWidth-1:0]   prefetch_loop_jump_addr_i,
  input  logic                       prefetch_ignore_errs_i,

  output logic                       fetch_en_o,
  output logic [ImemAddrWidth-1:0]   prefetch_addr_o,
  output logic                       insn_addr_err_o
);

  import insn_pkg::*;
  import ifetch_pkg::*;

  logic [ImemAddrWidth-1:0] prefetch_addr_q;
  logic                     prefetch_upd;
  logic                     rvalid_kill_q, rvalid_kill_d;
  logic                     rvalid_final;
  logic                     addr_match;
  logic                     prefetch_miss;
  logic                     rdata_is_branch;
  insn_t                    rdata_insn;

  // A read is discarded in the cycle after a branch was seen
  assign rvalid_final = imem_rvalid_i & ~rvalid_kill_q;
  assign addr_match   = (insn_fetch_req_addr_i == prefetch_addr_q);

  // Either nothing useful was read or it was read from the wrong place
  assign prefetch_miss = insn_fetch_req_valid_i & (~rvalid_final | ~addr_match);

  assign rdata_insn      = imem_rdata_i[31:0];
  assign rdata_is_branch = rdata_insn[6:0] inside {InsnOpcodeBranch, InsnOpcodeJal,
                                                   InsnOpcodeJalr};

  always_comb begin
    imem_addr_o   = prefetch_addr_q + ImemAddrWidth'(4);
    rvalid_kill_d = 1'b0;
    prefetch_upd  = prefetch_en_i;

    if (!insn_fetch_req_valid_i) begin
      // Stalled, so keep reading the word the execute stage will want next
      imem_addr_o = prefetch_addr_q;
    end else if (prefetch_miss) begin
      imem_addr_o = insn_fetch_req_addr_i;
    end else if (rdata_is_branch) begin
      // Taken or not is unknown here, so stop prefetching and drop the next read.
      // The request still goes out, only its result is thrown away
      rvalid_kill_d = 1'b1;
      prefetch_upd  = 1'b0;
    end else if ({1'b0, prefetch_addr_q} == prefetch_loop_end_addr_i &&
                 prefetch_loop_active_i &&
                 prefetch_loop_iterations_i > loop_iter_t'(1)) begin
      imem_addr_o = prefetch_loop_jump_addr_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      prefetch_addr_q <= '0;
      rvalid_kill_q   <= 1'b0;
    end else begin
      rvalid_kill_q <= rvalid_kill_d;
      if (prefetch_upd) begin
        prefetch_addr_q <= imem_addr_o;
      end
    end
  end

  assign fetch_en_o      = insn_fetch_req_valid_i & rvalid_final & addr_match;
  assign prefetch_addr_o = prefetch_addr_q;

  // A valid read to another address than requested means the prefetcher went wrong
  assign insn_addr_err_o = insn_fetch_req_valid_i & rvalid_final & ~addr_match &
                           ~prefetch_ignore_errs_i;

endmodule

`default_nettype wire

//--- rtl/ifetch_top.sv
////////////////////////////////////////////////////////////
// Instruction fetch stage. Memory has a fixed one-cycle read
// and no back-pressure; error gating is done by the caller.
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module ifetch_top #(
  parameter int  ImemSizeByte  = ifetch_pkg::ImemSizeByteDefault,
  localparam int ImemAddrWidth = $clog2(ImemSizeByte)
) (
  input  logic                     clk_i,
  input  logic                     rst_ni,

  // Instruction memory, read only
  output logic                     imem_req_o,
  output logic [ImemAddrWidth-1:0] imem_addr_o,
  input  insn_pkg::insn_intg_t     imem_rdata_i,
  input  logic                     imem_rvalid_i,

  // Requests from the execute stage
  input  logic                     insn_fetch_req_valid_i,
  input  logic [ImemAddrWidth-1:0] insn_fetch_req_addr_i,

  output logic                     insn_fetch_resp_valid_o,
  output logic [ImemAddrWidth-1:0] insn_fetch_resp_addr_o,
  output insn_pkg::insn_t          insn_fetch_resp_data_o,
  input  logic                     insn_fetch_resp_clear_i,

  output logic                     insn_fetch_err_o,
  output logic                     insn_addr_err_o,

  input  logic                     prefetch_en_i,
  input  logic                     prefetch_loop_active_i,
  input  ifetch_pkg::loop_iter_t   prefetch_loop_iterations_i,
  input  logic [ImemAddrWidth:0]   prefetch_loop_end_addr_i,
  input  logic [ImemAddrWidth-1:0] prefetch_loop_jump_addr_i,
  input  logic                     prefetch_ignore_errs_i
);

  import insn_pkg::*;

  logic                     fetch_en;
  logic [ImemAddrWidth-1:0] prefetch_addr;
  logic                     resp_valid;
  insn_intg_t               resp_word;

  ifetch_prefetch #(
    .ImemAddrWidth(ImemAddrWidth)
  ) u_prefetch (
    .clk_i                     (clk_i),
    .rst_ni                    (rst_ni),
    .imem_rdata_i              (imem_rdata_i),
    .imem_rvalid_i             (imem_rvalid_i),
    .imem_addr_o               (imem_addr_o),
    .insn_fetch_req_valid_i    (insn_fetch_req_valid_i),
    .insn_fetch_req_addr_i     (insn_fetch_req_addr_i),
    .prefetch_en_i             (prefetch_en_i),
    .prefetch_loop_active_i    (prefetch_loop_active_i),
    .prefetch_loop_iterations_i(prefetch_loop_iterations_i),
    .prefetch_loop_end_addr_i  (prefetch_loop_end_addr_i),
    .prefetch_loop_jump_addr_i (prefetch_loop_jump_addr_i),
    .prefetch_ignore_errs_i    (prefetch_ignore_errs_i),
    .fetch_en_o                (fetch_en),
    .prefetch_addr_o           (prefetch_addr),
    .insn_addr_err_o           (insn_addr_err_o)
  );

  ifetch_resp #(
    .ImemAddrWidth(ImemAddrWidth)
  ) u_resp (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .fetch_en_i  (fetch_en),
    .fetch_addr_i(prefetch_addr),
    .imem_rdata_i(imem_rdata_i),
    .resp_clear_i(insn_fetch_resp_clear_i),
    .resp_valid_o(resp_valid),
    .resp_addr_o (insn_fetch_resp_addr_o),
    .resp_word_o (resp_word)
  );

  ifetch_intg_check u_intg_check (
    .word_i    (resp_word),
    .valid_i   (resp_valid),
    .intg_err_o(insn_fetch_err_o)
  );

  // The memory is read whenever the controller allows prefetching
  assign imem_req_o = prefetch_en_i;

  assign insn_fetch_resp_valid_o = resp_valid;
  // The decoder only sees the data bits
  assign insn_fetch_resp_data_o  = resp_word[InsnW-1:0];

endmodule

`default_nettype wire

//--- tests/tb_ifetch.sv
////////////////////////////////////////////////////////////
// Directed testbench. The memory model answers every request
// one cycle later; the run stops at the first mismatch.
////////////////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_ifetch;

  import insn_pkg::*;
  import ifetch_pkg::*;

  localparam int AddrW       = $clog2(ImemSizeByteDefault);
  localparam int ClkPeriod   = 40;
  localparam int ResetCycles = 8;
  localparam int TestCycles  = 60;

  localparam logic [AddrW-1:0] SeqBase    = 'h100;
  localparam logic [AddrW-1:0] BranchAddr = 'h200;
  localparam logic [AddrW-1:0] LoopJump   = 'h2C0;
  localparam logic [AddrW-1:0] LoopEnd    = 'h300;
  localparam logic [AddrW-1:0] IntgAddr   = 'h400;
  localparam logic [AddrW-1:0] ErrAddr    = 'h500;
  localparam logic [AddrW-1:0] StallAddr  = 'h600;

  logic             clk;
  logic             rst_n;
  logic             imem_req;
  logic [AddrW-1:0] imem_addr;
  insn_intg_t       imem_rdata;
  logic             imem_rvalid;
  logic             req_valid;
  logic [AddrW-1:0] req_addr;
  logic             resp_valid;
  logic [AddrW-1:0] resp_addr;
  insn_t            resp_data;
  logic             resp_clear;
  logic             fetch_err;
  logic             addr_err;
  logic             prefetch_en;
  logic             loop_active;
  loop_iter_t       loop_iterations;
  logic [AddrW:0]   loop_end_addr;
  logic [AddrW-1:0] loop_jump_addr;
  logic             ignore_errs;
  insn_intg_t       mem [ImemSizeByteDefault/4];
  logic             mem_req_q;
  logic [AddrW-1:0] mem_addr_q;

  ifetch_top #(
    .ImemSizeByte(ImemSizeByteDefault)
  ) u_dut (
    .clk_i                     (clk),
    .rst_ni                    (rst_n),
    .imem_req_o                (imem_req),
    .imem_addr_o               (imem_addr),
    .imem_rdata_i              (imem_rdata),
    .imem_rvalid_i             (imem_rvalid),
    .insn_fetch_req_valid_i    (req_valid),
    .insn_fetch_req_addr_i     (req_addr),
    .insn_fetch_resp_valid_o   (resp_valid),
    .insn_fetch_resp_addr_o    (resp_addr),
    .insn_fetch_resp_data_o    (resp_data),
    .insn_fetch_resp_clear_i   (resp_clear),
    .insn_fetch_err_o          (fetch_err),
    .insn_addr_err_o           (addr_err),
    .prefetch_en_i             (prefetch_en),
    .prefetch_loop_active_i    (loop_active),
    .prefetch_loop_iterations_i(loop_iterations),
    .prefetch_loop_end_addr_i  (loop_end_addr),
    .prefetch_loop_jump_addr_i (loop_jump_addr),
    .prefetch_ignore_errs_i    (ignore_errs)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  // Memory samples the request mid-cycle and answers in the next cycle
  initial begin
    imem_rvalid = 1'b0;
    imem_rdata  = '0;
    forever begin
      @(negedge clk);
      mem_req_q  = imem_req;
      mem_addr_q = imem_addr;
      @(posedge clk);
      #1;
      imem_rvalid = mem_req_q;
      imem_rdata  = mem[mem_addr_q[AddrW-1:2]];
    end
  end

  function automatic insn_intg_t encode_word(input insn_t data);
    insn_chk_t chk;
    for (int k = 0; k < InsnIntgChkW; k++) begin
      chk[k] = ^(data & InsnIntgMask[k]);
    end
    return {chk ^ InsnIntgInv, data};
  endfunction

  task automatic stop_with_failure(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      stop_with_failure($sformatf("Error: %s is 0x%0h, expected 0x%0h", name, got, exp));
    end
  endtask

  // Valid response for addr; a word that does not re-encode to itself must be flagged
  task automatic check_resp(input logic [AddrW-1:0] addr);
    insn_intg_t word;
    word = mem[addr[AddrW-1:2]];
    check_eq("insn_fetch_resp_valid_o", 32'(resp_valid), 32'h1);
    check_eq("insn_fetch_resp_addr_o", 32'(resp_addr), 32'(addr));
    check_eq("insn_fetch_resp_data_o", resp_data, word[31:0]);
    check_eq("insn_fetch_err_o", 32'(fetch_err), 32'(encode_word(word[31:0]) != word));
  endtask

  // One clock cycle of execute-side inputs, returning mid-cycle for checks
  task automatic drive_cycle(input logic valid, input logic [AddrW-1:0] addr, input logic clr);
    @(posedge clk);
    #1;
    req_valid  = valid;
    req_addr   = addr;
    resp_clear = clr;
    @(negedge clk);
  endtask

  task automatic fill_memory();
    insn_t data;
    for (int i = 0; i < ImemSizeByteDefault / 4; i++) begin
      data      = (i * 32'h9E37_79B1) ^ 32'hA5C3_0000;
      // Filler words are ALU ops so only planted words redirect the prefetcher
      data[6:0] = 7'b0010011;
      mem[(AddrW-2)'(i)] = encode_word(data);
    end
    mem[BranchAddr[AddrW-1:2]] = encode_word(32'h00B5_0463);
    mem[IntgAddr[AddrW-1:2]]   = encode_word(32'h1234_5613) ^ (insn_intg_t'(1) << 9);
  endtask

  task automatic test_sequential();
    drive_cycle(1'b0, '0, 1'b0);
    drive_cycle(1'b1, SeqBase, 1'b0);
    check_eq("imem_addr_o", 32'(imem_addr), 32'(SeqBase));
    check_eq("imem_req_o", 32'(imem_req), 32'(prefetch_en));
    for (int i = 0; i < 8; i++) begin
      drive_cycle(1'b1, SeqBase + AddrW'(4 * i), 1'b0);
      check_eq("insn_addr_err_o", 32'(addr_err), 32'h0);
      if (i > 0) begin
        check_resp(SeqBase + AddrW'(4 * (i - 1)));
      end
    end
    drive_cycle(1'b0, '0, 1'b0);
    check_resp(SeqBase + AddrW'(28));
  endtask

  task automatic test_branch();
    drive_cycle(1'b0, '0, 1'b0);
    drive_cycle(1'b1, BranchAddr, 1'b0);
    drive_cycle(1'b1, BranchAddr, 1'b0);
    // The read behind the branch is dropped, so the next word misses
    drive_cycle(1'b1, BranchAddr + AddrW'(4), 1'b0);
    check_resp(BranchAddr);
    check_eq("insn_addr_err_o", 32'(addr_err), 32'h0);
    drive_cycle(1'b1, BranchAddr + AddrW'(4), 1'b0);
    check_eq("insn_fetch_resp_addr_o", 32'(resp_addr), 32'(BranchAddr));
    check_eq("insn_addr_err_o", 32'(addr_err), 32'h0);
    drive_cycle(1'b0, '0, 1'b0);
    check_resp(BranchAddr + AddrW'(4));
  endtask

  task automatic test_loop();
    @(posedge clk);
    #1;
    loop_active     = 1'b1;
    loop_iterations = loop_iter_t'(3);
    loop_end_addr   = {1'b0, LoopEnd};
    loop_jump_addr  = LoopJump;
    drive_cycle(1'b1, LoopEnd - AddrW'(4), 1'b0);
    drive_cycle(1'b1, LoopEnd - AddrW'(4), 1'b0);
    drive_cycle(1'b1, LoopEnd, 1'b0);
    check_resp(LoopEnd - AddrW'(4));
    check_eq("insn_addr_err_o", 32'(addr_err), 32'h0);
    check_eq("imem_addr_o", 32'(imem_addr), 32'(LoopJump));
    drive_cycle(1'b1, LoopJump, 1'b0);
    check_resp(LoopEnd);
    check_eq("insn_addr_err_o", 32'(addr_err), 32'h0);
    drive_cycle(1'b0, '0, 1'b0);
    check_resp(LoopJump);
    @(posedge clk);
    #1;
    loop_active = 1'b0;
  endtask

  task automatic test_integrity();
    drive_cycle(1'b0, '0, 1'b0);
    drive_cycle(1'b1, IntgAddr, 1'b0);
    drive_cycle(1'b1, IntgAddr, 1'b0);
    drive_cycle(1'b1, IntgAddr + AddrW'(4), 1'b0);
    check_eq("insn_fetch_err_o", 32'(fetch_err), 32'h1);
    check_resp(IntgAddr);
    drive_cycle(1'b0, '0, 1'b0);
    check_eq("insn_fetch_err_o", 32'(fetch_err), 32'h0);
    check_resp(IntgAddr + AddrW'(4));
  endtask

  task automatic test_stall_clear();
    drive_cycle(1'b0, '0, 1'b0);
    drive_cycle(1'b1, StallAddr, 1'b0);
    drive_cycle(1'b1, StallAddr, 1'b0);
    repeat (4) begin
      drive_cycle(1'b0, '0, 1'b0);
      check_resp(StallAddr);
      check_eq("imem_addr_o", 32'(imem_addr), 32'(StallAddr + AddrW'(4)));
    end
    drive_cycle(1'b0, '0, 1'b1);
    check_eq("insn_fetch_resp_valid_o", 32'(resp_valid), 32'h1);
    drive_cycle(1'b0, '0, 1'b0);
    check_eq("insn_fetch_resp_valid_o", 32'(resp_valid), 32'h0);
    check_eq("insn_fetch_resp_addr_o", 32'(resp_addr), 32'(StallAddr));
  endtask

  // Prefetch sits one word ahead, then the request skips past it
  task automatic test_addr_err(input logic ign);
    @(posedge clk);
    #1;
    ignore_errs = ign;
    drive_cycle(1'b1, ErrAddr, 1'b0);
    drive_cycle(1'b1, ErrAddr, 1'b0);
    drive_cycle(1'b1, ErrAddr + AddrW'(12), 1'b0);
    check_eq("insn_addr_err_o", 32'(addr_err), 32'(!ign));
    drive_cycle(1'b0, '0, 1'b0);
  endtask

  initial begin
    #((ResetCycles + TestCycles) * ClkPeriod * 2);
    stop_with_failure("Timeout: the tests did not finish within the expected number of cycles");
  end

  initial begin
    fill_memory();
    rst_n           = 1'b0;
    req_valid       = 1'b0;
    req_addr        = '0;
    resp_clear      = 1'b0;
    prefetch_en     = 1'b1;
    loop_active     = 1'b0;
    loop_iterations = '0;
    loop_end_addr   = '0;
    loop_jump_addr  = '0;
    ignore_errs     = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_sequential();
    test_branch();
    test_loop();
    test_integrity();
    test_stall_clear();
    test_addr_err(1'b0);
    test_addr_err(1'b1);
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- ifetch.f
rtl/insn_pkg.sv
rtl/ifetch_pkg.sv
rtl/ifetch_intg_check.sv
rtl/ifetch_resp.sv
rtl/ifetch_prefetch.sv
rtl/ifetch_top.sv
tests/tb_ifetch.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert --timescale 1ns/1ns
TOP       = tb_ifetch
FILELIST  = ifetch.f
OBJ_DIR   = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The binary exits with a non-zero status when the testbench stops with $fatal
run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
